//--- files.f
+incdir+verilog
verilog/flow_pkg.sv
verilog/ptr_ram_fifo.sv
verilog/ptr_prefetch_fifo.sv
verilog/flow_free_list.sv
verilog/alloc_credit_ctrl.sv
verilog/buf_alloc_top.sv
tests/buf_alloc_properties.sv
tests/tb_buf_alloc.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, and succeed only when the pass line is in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_buf_alloc \
    --Mdir obj_dir -o sim_tb || exit 1
out=$(./obj_dir/sim_tb 2>&1)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS" && exit 0 || exit 1

//--- tests/buf_alloc_properties.sv
// bound into two modules; ports a bind does not use are tied to constants that keep those checks idle.
module buf_alloc_properties
    import flow_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input credit_t     credit_cnt,
    input logic        alloc_valid,
    input logic        free_buf_rd,
    input logic        freeb_empty,
    input logic        rel_valid,
    input logic        init_done,
    input init_state_e init_st
);

    // ======================================================================
    // credit handshake.
    // ======================================================================

    a_issue_with_credit: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_valid |-> $past(credit_cnt != '0))
        else $error("alloc_valid issued with no credit held");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        free_buf_rd |-> !freeb_empty)
        else $error("free_buf_rd raised while the prefetch stage is empty");

    a_credit_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt == '1 |=> credit_cnt != '0) // full counter must not roll over.
        else $error("credit counter wrapped");

    // ======================================================================
    // init rules.
    // ======================================================================

    a_no_rel_in_init: assert property (@(posedge clk) disable iff (!rst_n)
        rel_valid |-> init_done)
        else $error("release seen while init is running");

    // init_done lags the state by a cycle, so this also covers the re-init edge.
    a_rel_only_when_live: assert property (@(posedge clk) disable iff (!rst_n)
        rel_valid |-> init_st == INIT_DONE)
        else $error("release seen while the fsm is outside INIT_DONE");

endmodule

bind flow_free_list buf_alloc_properties u_free_list_props (
    .clk, .rst_n, .credit_cnt('1), .alloc_valid(1'b0), .free_buf_rd, .freeb_empty,
    .rel_valid, .init_done, .init_st
);

bind alloc_credit_ctrl buf_alloc_properties u_alloc_props (
    .clk, .rst_n, .credit_cnt, .alloc_valid, .free_buf_rd, .freeb_empty,
    .rel_valid(1'b0), .init_done, .init_st(flow_pkg::INIT_DONE)
);

//--- tests/tb_buf_alloc.sv
// assumes a pool of 2**BPTR_NBITS pointers; table rows release only pointers already allocated.
`include "flow_params.svh"

module tb_buf_alloc
    import flow_pkg::*;
();

    typedef enum int {OP_WAIT_INIT, OP_GRANT, OP_RELEASE, OP_REINIT, OP_IDLE} op_e;

    localparam int n_rows         = 13;
    localparam int timeout_cycles = 100; // per wait.
    localparam int pool_size      = 1 << `BPTR_NBITS;

    // ======================================================================
    // stimulus table.
    // ======================================================================

    // operation, credits or pointer, then free_count and freeb_empty at row end.
    op_e        tbl_op    [n_rows] = '{OP_WAIT_INIT, OP_GRANT, OP_IDLE, OP_GRANT, OP_GRANT,
                                       OP_RELEASE, OP_RELEASE, OP_RELEASE, OP_IDLE, OP_GRANT,
                                       OP_REINIT, OP_GRANT, OP_IDLE};
    int         tbl_arg   [n_rows] = '{0, 5, 0, 7, 4, 9, 3, 12, 0, 3, 0, 2, 0};
    buf_count_t tbl_count [n_rows] = '{5'd16, 5'd11, 5'd11, 5'd4, 5'd0, 5'd0, 5'd0, 5'd0,
                                       5'd3, 5'd0, 5'd16, 5'd14, 5'd14};
    logic       tbl_empty [n_rows] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                       1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

    logic       clk;
    logic       rst_n;
    logic       freeb_init;
    logic       rel_valid;
    buf_ptr_t   rel_ptr;
    logic       alloc_credit;
    logic       alloc_valid;
    buf_ptr_t   alloc_ptr;
    logic       init_done;
    buf_count_t free_count;
    logic       freeb_empty;

    buf_ptr_t model [$];  // pointers due next, oldest first.
    integer   seed;
    int       row_allocs; // allocations seen in the current row.
    int       val_errs;
    int       other_errs;

    buf_alloc_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // compare tasks and model.
    // ======================================================================

    task automatic check_ptr(input string name, input buf_ptr_t got, input buf_ptr_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input buf_count_t got, input buf_count_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            val_errs++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // the whole pool comes back in order after init.
    task automatic refill_model();
        model.delete();
        for (int i = 0; i < pool_size; i++) model.push_back(buf_ptr_t'(i));
    endtask

    // next falling edge; outputs are stable here, so score any allocation.
    task automatic tick();
        @(negedge clk);
        if (alloc_valid === 1'b1) begin
            row_allocs++;
            if (model.size() == 0) begin
                other_errs++;
                $display("alloc_valid fired with no free pointer left in the model");
            end else begin
                check_ptr("alloc_ptr", alloc_ptr, model.pop_front());
            end
        end
    endtask

    function automatic logic reached(input string what, input int level);
        if (what == "init_done") return init_done === level[0];
        if (what == "freeb_empty") return freeb_empty === level[0];
        return row_allocs >= level; // allocation count.
    endfunction

    task automatic wait_for(input string what, input int level);
        int n;
        n = 0;
        while (!reached(what, level) && n < timeout_cycles) begin
            tick();
            n++;
        end
        if (!reached(what, level)) begin
            other_errs++;
            $display("timeout: %s did not reach %0d within %0d cycles", what, level, n);
        end
    endtask

    // ======================================================================
    // main sequence.
    // ======================================================================

    initial begin
        int gap;
        seed         = 32'h1cb1;
        rst_n        = 1'b0;
        freeb_init   = 1'b0;
        rel_valid    = 1'b0;
        rel_ptr      = '0;
        alloc_credit = 1'b0;
        row_allocs   = 0;
        val_errs     = 0;
        other_errs   = 0;
        refill_model();
        repeat (5) tick();
        rst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            row_allocs = 0;
            case (tbl_op[r])
                OP_WAIT_INIT: wait_for("init_done", 1);
                OP_GRANT: begin
                    for (int k = 0; k < tbl_arg[r]; k++) begin
                        alloc_credit = 1'b1; // one credit per pulse.
                        tick();
                        alloc_credit = 1'b0;
                        gap = $random(seed) & 3;
                        repeat (gap) tick();
                    end
                    wait_for("allocations", tbl_arg[r]);
                end
                OP_RELEASE: begin
                    rel_valid = 1'b1;
                    rel_ptr   = buf_ptr_t'(tbl_arg[r]);
                    tick();
                    rel_valid = 1'b0;
                    model.push_back(buf_ptr_t'(tbl_arg[r])); // recycled fifo order.
                end
                OP_REINIT: begin
                    freeb_init = 1'b1;
                    tick();
                    freeb_init = 1'b0;
                    wait_for("init_done", 0);
                    refill_model();
                    wait_for("init_done", 1);
                end
                default: begin
                    gap = 4 + ($random(seed) & 7); // no credits held, nothing may issue.
                    repeat (gap) tick();
                end
            endcase
            check_count("allocations", buf_count_t'(row_allocs),
                        buf_count_t'(tbl_op[r] == OP_GRANT ? tbl_arg[r] : 0));
            // release rows are scored by the idle row that follows them.
            if (tbl_op[r] != OP_RELEASE) begin
                wait_for("freeb_empty", int'(tbl_empty[r]));
                check_count("free_count", free_count, tbl_count[r]);
                check_flag("freeb_empty", freeb_empty, tbl_empty[r]);
            end
        end
        $display("value errors %0d, other errors %0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/alloc_credit_ctrl.sv
// one pointer per credit; the consumer must never hold more credits than the counter can count.
module alloc_credit_ctrl
    import flow_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     alloc_credit,  // one credit per pulse.
    input  logic     init_done,
    input  logic     freeb_empty,
    input  buf_ptr_t free_buf_ptr,
    output logic     free_buf_rd,   // pop toward the free list.
    output logic     alloc_valid,
    output buf_ptr_t alloc_ptr
);

    credit_t credit_cnt;
    logic    has_credit;

    // ======================================================================
    // pop decision. combinational so the head is taken this cycle.
    // ======================================================================

    assign has_credit  = (credit_cnt != '0);
    assign free_buf_rd = has_credit & init_done & ~freeb_empty;

    // ======================================================================
    // credit counter.
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= '0;
        end else begin
            case ({alloc_credit, free_buf_rd})
                2'b10:   credit_cnt <= credit_cnt + 1'b1; // grant only.
                2'b01:   credit_cnt <= credit_cnt - 1'b1; // spend only.
                default: credit_cnt <= credit_cnt;        // both cancel.
            endcase
        end
    end

    // ======================================================================
    // toward the consumer. one cycle after the pop.
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alloc_valid <= 1'b0;
        end else begin
            alloc_valid <= free_buf_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (free_buf_rd) begin
            alloc_ptr <= free_buf_ptr; // held until the next pop.
        end
    end

endmodule

//--- verilog/buf_alloc_top.sv
// no release back-pressure; the source never releases more than was allocated.
module buf_alloc_top
    import flow_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       freeb_init,   // re-init after init_done.
    input  logic       rel_valid,
    input  buf_ptr_t   rel_ptr,
    input  logic       alloc_credit,
    output logic       alloc_valid,
    output buf_ptr_t   alloc_ptr,
    output logic       init_done,
    output buf_count_t free_count,
    output logic       freeb_empty
);

    // ======================================================================
    // free list to allocator.
    // ======================================================================

    logic     free_buf_rd;   // pop strobe.
    buf_ptr_t free_buf_ptr;  // prefetch head.

    // pointer pool with init, release and prefetch.
    flow_free_list u_free_list (
        .clk          (clk),
        .rst_n        (rst_n),
        .freeb_init   (freeb_init),
        .rel_valid    (rel_valid),
        .rel_ptr      (rel_ptr),
        .free_buf_rd  (free_buf_rd),
        .free_buf_ptr (free_buf_ptr),
        .freeb_empty  (freeb_empty),
        .init_done    (init_done),
        .free_count   (free_count)
    );

    // credit flow control toward the consumer.
    alloc_credit_ctrl u_alloc_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_credit (alloc_credit),
        .init_done    (init_done),
        .freeb_empty  (freeb_empty),
        .free_buf_ptr (free_buf_ptr),
        .free_buf_rd  (free_buf_rd),
        .alloc_valid  (alloc_valid),
        .alloc_ptr    (alloc_ptr)
    );

endmodule

//--- verilog/flow_free_list.sv
// releases during init are not supported; free_buf_rd must only be raised while freeb_empty is low.
module flow_free_list
    import flow_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       freeb_init,   // re-init request, honoured in INIT_DONE.
    input  logic       rel_valid,
    input  buf_ptr_t   rel_ptr,
    input  logic       free_buf_rd,  // pop, pointer taken same cycle.
    output buf_ptr_t   free_buf_ptr,
    output logic       freeb_empty,
    output logic       init_done,
    output buf_count_t free_count
);

    init_state_e init_st;
    init_state_e nxt_init_st;

    // release path, one stage of registering before the ram fifo.
    logic     rel_valid_d1;
    buf_ptr_t rel_ptr_d1;

    // ram fifo side.
    logic     fifo_clr;
    logic     init_wr;
    logic     fifo_wr;
    logic     fifo_wr_d1;
    logic     fifo_rd;
    logic     fifo_rd_d1;
    logic     fifo_empty;
    buf_ptr_t fifo_din;
    buf_ptr_t fifo_dout;
    buf_ptr_t fifo_wptr;

    // prefetch side.
    logic pf_wr;
    logic pf_rd;
    logic pf_full;
    logic pf_fullm1;

    // ======================================================================
    // init state machine.
    // ======================================================================

    always_comb begin
        nxt_init_st = init_st;
        case (init_st)
            INIT_IDLE:   nxt_init_st = RESET_FREEB;
            RESET_FREEB: nxt_init_st = INIT_FREEB;
            INIT_FREEB:  if (&fifo_wptr) nxt_init_st = INIT_DONE; // last pointer going in.
            INIT_DONE:   if (freeb_init) nxt_init_st = INIT_IDLE;
            default:     nxt_init_st = INIT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_st   <= INIT_IDLE;
            init_done <= 1'b0;
        end else begin
            init_st   <= nxt_init_st;
            init_done <= (init_st == INIT_DONE); // one cycle behind the state.
        end
    end

    assign fifo_clr = (init_st == RESET_FREEB);
    assign init_wr  = (init_st == INIT_FREEB);

    // ======================================================================
    // ram fifo write. init pointers or registered releases.
    // ======================================================================

    always_ff @(posedge clk) begin
        rel_ptr_d1 <= rel_ptr; // payload, no reset.
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rel_valid_d1 <= 1'b0;
            fifo_rd_d1   <= 1'b0;
            fifo_wr_d1   <= 1'b0;
        end else begin
            rel_valid_d1 <= rel_valid;
            fifo_rd_d1   <= fifo_rd;  // ram dout valid now.
            fifo_wr_d1   <= fifo_wr;  // count follows a write by one cycle.
        end
    end

    // during init the write pointer itself is the next free buffer.
    assign fifo_din = init_wr ? fifo_wptr : rel_ptr_d1;
    assign fifo_wr  = init_wr | rel_valid_d1;

    // ======================================================================
    // prefetch feed.
    // ======================================================================

    // hold off when a read in flight would fill the last slot.
    assign fifo_rd = (init_st == INIT_DONE) & ~fifo_empty &
                     ~(pf_full | (pf_wr & pf_fullm1));
    assign pf_wr   = fifo_rd_d1;
    assign pf_rd   = init_done & free_buf_rd;

    ptr_ram_fifo u_ram_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (fifo_clr),
        .din   (fifo_din),
        .wr    (fifo_wr),
        .rd    (fifo_rd),
        .dout  (fifo_dout),
        .wptr  (fifo_wptr),
        .count (),          // pool occupancy is tracked by free_count.
        .full  (),          // depth equals the pool, never fills.
        .empty (fifo_empty)
    );

    ptr_prefetch_fifo u_prefetch_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .clr    (fifo_clr),
        .din    (fifo_dout),
        .wr     (pf_wr),
        .rd     (pf_rd),
        .dout   (free_buf_ptr),
        .full   (pf_full),
        .fullm1 (pf_fullm1),
        .empty  (freeb_empty)
    );

    // ======================================================================
    // free-buffer count.
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n || fifo_clr) begin
            free_count <= '0;
        end else begin
            free_count <= free_count + buf_count_t'(fifo_wr_d1) - buf_count_t'(pf_rd);
        end
    end

endmodule

//--- verilog/flow_params.svh
// pool size is 2**BPTR_NBITS; the consumer must keep outstanding credits below 2**ALLOC_CREDIT_NBITS.
`ifndef FLOW_PARAMS_SVH
`define FLOW_PARAMS_SVH

// ======================================================================
// buffer pool sizing.
// ======================================================================

// pointer width. 4 bits gives a pool of 16 buffers.
`define BPTR_NBITS 4

// entries in the show-ahead stage in front of the consumer.
`define PREFETCH_DEPTH 2

// ======================================================================
// allocation flow control.
// ======================================================================

`define ALLOC_CREDIT_NBITS 3 // at most 7 credits outstanding.

`endif

//--- verilog/flow_pkg.sv
// widths follow flow_params.svh; the init states are ordered to match the init sequence.
`include "flow_params.svh"

package flow_pkg;

    // ======================================================================
    // datapath types.
    // ======================================================================

    // one buffer pointer.
    typedef logic [`BPTR_NBITS-1:0] buf_ptr_t;

    // free-buffer or fifo occupancy, one bit wider so a full pool fits.
    typedef logic [`BPTR_NBITS:0] buf_count_t;

    typedef logic [`ALLOC_CREDIT_NBITS-1:0] credit_t; // consumer credits held.

    // ======================================================================
    // free list init sequence.
    // ======================================================================

    typedef enum logic [1:0] {
        INIT_IDLE   = 2'd0, // entered from reset or re-init.
        RESET_FREEB = 2'd1, // fifos cleared here.
        INIT_FREEB  = 2'd2, // one pointer written per cycle.
        INIT_DONE   = 2'd3  // pool live.
    } init_state_e;

endpackage

//--- verilog/ptr_prefetch_fifo.sv
// small flop fifo with show-ahead output; the feeder must respect full and fullm1.
`include "flow_params.svh"

module ptr_prefetch_fifo
    import flow_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clr,
    input  buf_ptr_t din,
    input  logic     wr,
    input  logic     rd,
    output buf_ptr_t dout,   // head entry while not empty.
    output logic     full,
    output logic     fullm1, // one slot left.
    output logic     empty
);

    localparam int DEPTH = `PREFETCH_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    buf_ptr_t        mem [DEPTH];
    logic [AW-1:0]   wptr;
    logic [AW-1:0]   rptr;
    logic [CW-1:0]   count;
    logic            do_wr;
    logic            do_rd;

    // wrap at DEPTH, which need not be a power of two.
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        next_ptr = (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_wr  = wr & ~full & ~clr;
    assign do_rd  = rd & ~empty & ~clr;
    assign dout   = mem[rptr]; // show-ahead.
    assign full   = (count == CW'(DEPTH));
    assign fullm1 = (count == CW'(DEPTH - 1));
    assign empty  = (count == '0);

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= din; // payload only.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) wptr <= next_ptr(wptr);
            if (do_rd) rptr <= next_ptr(rptr);
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- verilog/ptr_ram_fifo.sv
// depth is fixed at 2**BPTR_NBITS; dout is valid the cycle after rd, writes when full are dropped.
`include "flow_params.svh"

module ptr_ram_fifo
    import flow_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clr,     // restart pointers and count.
    input  buf_ptr_t   din,
    input  logic       wr,
    input  logic       rd,
    output buf_ptr_t   dout,
    output buf_ptr_t   wptr,    // next slot to be written.
    output buf_count_t count,
    output logic       full,
    output logic       empty
);

    localparam int DEPTH = 1 << `BPTR_NBITS;

    buf_ptr_t mem [DEPTH];
    buf_ptr_t rptr;
    logic     do_wr;
    logic     do_rd;

    // guard the strobes so a bad request cannot corrupt the count.
    assign do_wr = wr & ~full & ~clr;
    assign do_rd = rd & ~empty & ~clr;

    assign full  = (count == buf_count_t'(DEPTH));
    assign empty = (count == '0);

    // ======================================================================
    // storage. synchronous read, no reset on the array or dout.
    // ======================================================================

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rptr]; // lands one cycle after rd.
        end
    end

    // ======================================================================
    // pointers and occupancy.
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1; // natural wrap, depth is a power of two.
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // idle or both.
            endcase
        end
    end

endmodule
